/* build.f */
+incdir+dv
logic/id_pkg.sv
logic/id_decoder.sv
logic/id_regfile.sv
logic/id_operand_fwd.sv
logic/id_branch_unit.sv
logic/id_ex_reg.sv
logic/id_stage.sv
dv/tb_id_stage.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -f build.f --top-module tb_id_stage -o sim_id_stage &&
./obj_dir/sim_id_stage | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run.sh: simulation passed" ||
{
    echo "run.sh: build or simulation failed"
    exit 1
}

/* dv/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [31:0]        shadow_regs [32]; // Follows the WB writes driven into the DUT
id_pkg::ex_bundle_t exp_ex;           // Expected ID/EX contents

// Decode straight from the raw word and the RV32I encoding tables
function automatic id_pkg::dec_ctrl_t ref_decode(input logic [31:0] w, output logic [31:0] imm);
    id_pkg::dec_ctrl_t c;
    id_pkg::alu_op_e   op;
    logic [31:0]       imm_i;
    c     = '0;
    imm   = '0;
    imm_i = {{20{w[31]}}, w[31:20]};
    case (w[14:12])
        3'd0:    op = (w[6:0] == id_pkg::OPC_OP && w[30]) ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
        3'd1:    op = id_pkg::ALU_SLL;
        3'd2:    op = id_pkg::ALU_SLT;
        3'd3:    op = id_pkg::ALU_SLTU;
        3'd4:    op = id_pkg::ALU_XOR;
        3'd5:    op = w[30] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
        3'd6:    op = id_pkg::ALU_OR;
        default: op = id_pkg::ALU_AND;
    endcase
    case (w[6:0])
        id_pkg::OPC_OP:
        begin
            c.alu_op = op;
            c.reg_wr = 1'b1;
            c.rd     = w[11:7];
            c.rs1    = w[19:15];
            c.rs2    = w[24:20];
        end
        id_pkg::OPC_OP_IMM:
        begin
            c.alu_op  = op;
            c.src_imm = 1'b1;
            c.reg_wr  = 1'b1;
            c.rd      = w[11:7];
            c.rs1     = w[19:15];
            imm       = imm_i;
        end
        id_pkg::OPC_LOAD:
        begin
            c.src_imm  = 1'b1;
            c.mem_rd   = 1'b1;
            c.mem_size = w[14:12];
            c.reg_wr   = 1'b1;
            c.rd       = w[11:7];
            c.rs1      = w[19:15];
            imm        = imm_i;
        end
        id_pkg::OPC_STORE:
        begin
            c.src_imm  = 1'b1;
            c.mem_wr   = 1'b1;
            c.mem_size = w[14:12];
            c.rs1      = w[19:15];
            c.rs2      = w[24:20];
            imm        = {{20{w[31]}}, w[31:25], w[11:7]};
        end
        id_pkg::OPC_BRANCH:
        begin
            case (w[14:12])
                3'd0:    c.br_op = id_pkg::BR_EQ;
                3'd1:    c.br_op = id_pkg::BR_NE;
                3'd4:    c.br_op = id_pkg::BR_LT;
                3'd5:    c.br_op = id_pkg::BR_GE;
                3'd6:    c.br_op = id_pkg::BR_LTU;
                3'd7:    c.br_op = id_pkg::BR_GEU;
                default: c.br_op = id_pkg::BR_NONE;
            endcase
            c.rs1 = w[19:15];
            c.rs2 = w[24:20];
            imm   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
        id_pkg::OPC_JAL:
        begin
            c.br_op  = id_pkg::BR_JAL;
            c.reg_wr = 1'b1;
            c.rd     = w[11:7];
            imm      = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        id_pkg::OPC_JALR:
        begin
            c.br_op   = id_pkg::BR_JALR;
            c.src_imm = 1'b1;
            c.reg_wr  = 1'b1;
            c.rd      = w[11:7];
            c.rs1     = w[19:15];
            imm       = imm_i;
        end
        id_pkg::OPC_LUI:
        begin
            c.alu_op  = id_pkg::ALU_PASS_B;
            c.src_imm = 1'b1;
            c.reg_wr  = 1'b1;
            c.rd      = w[11:7];
            imm       = {w[31:12], 12'b0};
        end
        default: ;
    endcase
    return c;
endfunction

function automatic logic [31:0] ref_forward(input logic [4:0] addr, input id_pkg::dec_ctrl_t exc,
                                            input logic [31:0] alu, input id_pkg::mem_fwd_t mem,
                                            input id_pkg::wb_write_t wb);
    if (addr == 5'd0)
        return 32'd0;
    if (exc.reg_wr && exc.rd == addr)
        return alu;
    if (mem.valid && mem.addr == addr)
        return mem.data;
    if (wb.valid && wb.addr == addr)
        return wb.data;
    return shadow_regs[addr];
endfunction

function automatic logic ref_stall(input id_pkg::dec_ctrl_t c, input id_pkg::dec_ctrl_t exc,
                                   input id_pkg::mem_fwd_t mem);
    logic ex_hit;
    logic mem_hit;
    ex_hit  = exc.mem_rd && exc.rd != 5'd0 && (exc.rd == c.rs1 || exc.rd == c.rs2);
    mem_hit = mem.is_load && mem.addr != 5'd0 && (mem.addr == c.rs1 || mem.addr == c.rs2);
    return ex_hit || mem_hit;
endfunction

function automatic void ref_branch(input id_pkg::br_op_e op, input logic [31:0] a,
                                   input logic [31:0] b, input logic [31:0] imm,
                                   input logic [31:0] pc, input logic stall,
                                   output logic taken, output logic [31:0] target);
    logic       cond;
    logic [31:0] sum;
    case (op)
        id_pkg::BR_EQ:   cond = (a == b);
        id_pkg::BR_NE:   cond = (a != b);
        id_pkg::BR_LT:   cond = ($signed(a) < $signed(b));
        id_pkg::BR_GE:   cond = !($signed(a) < $signed(b));
        id_pkg::BR_LTU:  cond = (a < b);
        id_pkg::BR_GEU:  cond = !(a < b);
        id_pkg::BR_JAL:  cond = 1'b1;
        id_pkg::BR_JALR: cond = 1'b1;
        default:         cond = 1'b0;
    endcase
    taken  = cond && !stall;
    sum    = a + imm;
    target = (op == id_pkg::BR_JALR) ? (sum & 32'hffff_fffe) : pc + imm;
endfunction

`endif

/* dv/tb_id_stage.sv */
module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TEST_CYCLES  = 200;
    localparam int NUM_TESTS    = 6;
    localparam int TOTAL_CYCLES = 16 + NUM_TESTS * (TEST_CYCLES + 2);

    logic               clk;
    logic               rst_n;
    id_pkg::instr_u     instr;
    logic [31:0]        pc;
    logic [31:0]        alu;
    id_pkg::mem_fwd_t   mem_fwd;
    id_pkg::wb_write_t  wb_write;
    logic               busy;
    id_pkg::ex_bundle_t ex;
    logic               stall;
    logic               brj;
    logic [31:0]        brj_pc;

    logic [31:0] lfsr = 32'hd676;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          busy_left;

    `include "tb_ref_model.svh"

    id_stage i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_i    (instr),
        .pc_i       (pc),
        .alu_i      (alu),
        .mem_fwd_i  (mem_fwd),
        .wb_write_i (wb_write),
        .busy_i     (busy),
        .ex_o       (ex),
        .stall_o    (stall),
        .brj_o      (brj),
        .brj_pc_o   (brj_pc)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Biased data so that equal and sign-edge operands show up often
    function automatic logic [31:0] rand_data();
        logic [1:0] kind;
        kind = 2'(rand_bits(2));
        case (kind)
            2'd0:    return rand_bits(2);
            2'd1:    return 32'hffff_fff0 | rand_bits(4);
            default: return rand_bits(32);
        endcase
    endfunction

    task automatic drive_cycle(input int mode);
        logic [31:0] w;
        logic [6:0]  opc;
        logic [2:0]  pick;
        logic [4:0]  amask;
        @(posedge clk);
        #1;
        w     = rand_bits(32);
        pick  = 3'(rand_bits(3));
        amask = (mode == 0 || mode == 4) ? 5'h1f : 5'h03; // Few registers means many hits
        case (mode)
            0:       opc = (pick == 3'd0) ? id_pkg::OPC_OP : (pick == 3'd1) ? id_pkg::OPC_OP_IMM :
                           (pick == 3'd2) ? id_pkg::OPC_LOAD : (pick == 3'd3) ? id_pkg::OPC_STORE :
                           (pick == 3'd4) ? id_pkg::OPC_LUI : 7'b1111111;
            1:       opc = id_pkg::OPC_OP;
            2:       opc = pick[0] ? id_pkg::OPC_LOAD : id_pkg::OPC_OP;
            3:       opc = (pick[1:0] == 2'd0) ? id_pkg::OPC_JAL :
                           (pick[1:0] == 2'd1) ? id_pkg::OPC_JALR : id_pkg::OPC_BRANCH;
            default: opc = pick[0] ? id_pkg::OPC_LOAD : (pick[1] ? id_pkg::OPC_OP : id_pkg::OPC_LUI);
        endcase
        w[6:0]   = opc;
        w[11:7]  = w[11:7] & amask;
        w[19:15] = w[19:15] & amask;
        w[24:20] = w[24:20] & amask;
        instr    = w;
        pc       = rand_bits(32) & 32'hffff_fffc;
        alu      = rand_data();
        mem_fwd.valid   = (mode != 0) && rand_bits(1) == 32'd1;
        mem_fwd.addr    = 5'(rand_bits(5)) & amask;
        mem_fwd.data    = rand_data();
        mem_fwd.is_load = (mode == 2) ? rand_bits(1) == 32'd1 :
                          (mode == 3) ? rand_bits(2) == 32'd0 : 1'b0;
        wb_write.valid  = rand_bits(1) == 32'd1;
        wb_write.addr   = 5'(rand_bits(5)) & amask;
        wb_write.data   = rand_data();
        if (mode == 4)
        begin
            if (busy_left == 0)
            begin
                busy      = ~busy;
                busy_left = 1 + rand_bits(2);
            end
            busy_left--;
        end
        else
            busy = 1'b0;
    endtask

    task automatic run_test(input string name, input int mode);
        int start_errors;
        start_errors = errors;
        busy_left    = 0;
        repeat (TEST_CYCLES) drive_cycle(mode);
        @(posedge clk);
        #1 busy = 1'b0;
        repeat (2) @(negedge clk); // Let the last captures be checked
        #1;
        if (errors == start_errors)
        begin
            tests_passed++;
            $display("Test %s finished: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s finished: %0d errors", name, errors - start_errors);
        end
    endtask

    // Checks outputs before each edge and the ID/EX shadow after it
    initial
    begin
        id_pkg::dec_ctrl_t  c;
        id_pkg::ex_bundle_t nxt;
        id_pkg::wb_write_t  wb_s;
        logic [31:0]        imm;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        tgt;
        logic               st;
        logic               tk;
        logic               hold;
        exp_ex = '0;
        for (int r = 0; r < 32; r++)
            shadow_regs[r] = '0;
        @(posedge rst_n);
        forever
        begin
            @(negedge clk);
            assert (ex === exp_ex) else
            begin
                $display("Mismatch ex_o: expected %h, got %h", exp_ex, ex);
                errors++;
            end
            c  = ref_decode(instr, imm);
            a  = ref_forward(c.rs1, exp_ex.ctrl, alu, mem_fwd, wb_write);
            b  = ref_forward(c.rs2, exp_ex.ctrl, alu, mem_fwd, wb_write);
            st = ref_stall(c, exp_ex.ctrl, mem_fwd);
            ref_branch(c.br_op, a, b, imm, pc, st, tk, tgt);
            assert (stall === st) else
            begin
                $display("Mismatch stall_o: expected %h, got %h", st, stall);
                errors++;
            end
            assert (brj === tk) else
            begin
                $display("Mismatch brj_o: expected %h, got %h", tk, brj);
                errors++;
            end
            assert (brj_pc === tgt) else
            begin
                $display("Mismatch brj_pc_o: expected %h, got %h", tgt, brj_pc);
                errors++;
            end
            nxt.ctrl   = c;
            nxt.rs1    = a;
            nxt.rs2    = b;
            nxt.imm    = imm;
            nxt.pc4    = pc + 32'd4;
            nxt.brj_pc = tgt;
            if (st)
            begin
                nxt.ctrl.reg_wr = 1'b0;
                nxt.ctrl.mem_rd = 1'b0;
                nxt.ctrl.mem_wr = 1'b0;
                nxt.ctrl.alu_op = id_pkg::ALU_ADD;
            end
            hold = busy;
            wb_s = wb_write;
            @(posedge clk);
            if (wb_s.valid && wb_s.addr != 5'd0)
                shadow_regs[wb_s.addr] = wb_s.data;
            if (!hold)
                exp_ex = nxt;
        end
    end

    initial
    begin
        #(TOTAL_CYCLES * 4 + 400);
        $display("Watchdog expired before the tests completed");
        $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        rst_n    = 1'b0;
        instr    = '0;
        pc       = '0;
        alu      = '0;
        mem_fwd  = '0;
        wb_write = '0;
        busy     = 1'b0;
        errors   = 0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        #1;
        assert (ex === '0) else
        begin
            $display("Mismatch ex_o after reset: expected 0, got %h", ex);
            errors++;
        end
        if (errors == 0)
        begin
            tests_passed++;
            $display("Test reset finished: ok");
        end
        else
        begin
            tests_failed++;
            $display("Test reset finished: %0d errors", errors);
        end
        run_test("decode", 0);
        run_test("forwarding", 1);
        run_test("load_use", 2);
        run_test("branch", 3);
        run_test("busy_hold", 4);
        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* logic/id_stage.sv */
module id_stage
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  id_pkg::instr_u          instr_i,
    input  logic [id_pkg::XLEN-1:0] pc_i,
    input  logic [id_pkg::XLEN-1:0] alu_i,      // EXE result
    input  id_pkg::mem_fwd_t        mem_fwd_i,
    input  id_pkg::wb_write_t       wb_write_i,
    input  logic                    busy_i,
    output id_pkg::ex_bundle_t      ex_o,
    output logic                    stall_o,
    output logic                    brj_o,
    output logic [id_pkg::XLEN-1:0] brj_pc_o
);

    id_pkg::dec_ctrl_t       ctrl;
    id_pkg::ex_bundle_t      next_bundle;
    logic [id_pkg::XLEN-1:0] imm;
    logic [id_pkg::XLEN-1:0] rf_rs1;
    logic [id_pkg::XLEN-1:0] rf_rs2;
    logic [id_pkg::XLEN-1:0] rs1_val;   // After forwarding
    logic [id_pkg::XLEN-1:0] rs2_val;

    id_decoder i_decoder (
        .instr_i (instr_i),
        .ctrl_o  (ctrl),
        .imm_o   (imm)
    );

    id_regfile i_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_write_i (wb_write_i),
        .rs1_addr_i (ctrl.rs1),
        .rs2_addr_i (ctrl.rs2),
        .rs1_data_o (rf_rs1),
        .rs2_data_o (rf_rs2)
    );

    id_operand_fwd i_operand_fwd (
        .ctrl_i     (ctrl),
        .rf_rs1_i   (rf_rs1),
        .rf_rs2_i   (rf_rs2),
        .ex_ctrl_i  (ex_o.ctrl),
        .alu_i      (alu_i),
        .mem_fwd_i  (mem_fwd_i),
        .wb_write_i (wb_write_i),
        .rs1_o      (rs1_val),
        .rs2_o      (rs2_val),
        .stall_o    (stall_o)
    );

    id_branch_unit i_branch_unit (
        .br_op_i  (ctrl.br_op),
        .rs1_i    (rs1_val),
        .rs2_i    (rs2_val),
        .imm_i    (imm),
        .pc_i     (pc_i),
        .stall_i  (stall_o),
        .brj_o    (brj_o),
        .brj_pc_o (brj_pc_o)
    );

    always_comb
    begin
        next_bundle.ctrl   = ctrl;
        next_bundle.rs1    = rs1_val;
        next_bundle.rs2    = rs2_val;
        next_bundle.imm    = imm;
        next_bundle.pc4    = pc_i + 32'd4; // Link value for JAL and JALR
        next_bundle.brj_pc = brj_pc_o;
    end

    id_ex_reg i_ex_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .busy_i  (busy_i),
        .stall_i (stall_o),
        .next_i  (next_bundle),
        .ex_o    (ex_o)
    );

endmodule

/* logic/id_ex_reg.sv */
module id_ex_reg
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               busy_i,   // Multi-cycle op in EXE
    input  logic               stall_i,  // Load-use stall
    input  id_pkg::ex_bundle_t next_i,
    output id_pkg::ex_bundle_t ex_o
);

    id_pkg::ex_bundle_t capture;

    always_comb
    begin
        capture = next_i;
        if (stall_i)
        begin
            capture.ctrl.reg_wr = 1'b0; // Turn the slot into a bubble
            capture.ctrl.mem_rd = 1'b0;
            capture.ctrl.mem_wr = 1'b0;
            capture.ctrl.alu_op = id_pkg::ALU_ADD;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ex_o <= '0;
        else if (!busy_i)
            ex_o <= capture;
    end

    squash_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stall_i && !busy_i) |=> (!ex_o.ctrl.reg_wr && !ex_o.ctrl.mem_rd
                                  && !ex_o.ctrl.mem_wr && ex_o.ctrl.alu_op == id_pkg::ALU_ADD)
    ) else $error("Stalled instruction reached EXE with side effects");

    hold_on_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        busy_i |=> $stable(ex_o)
    ) else $error("ID/EX bundle changed while busy");

endmodule

/* logic/id_branch_unit.sv */
module id_branch_unit
(
    input  id_pkg::br_op_e          br_op_i,
    input  logic [id_pkg::XLEN-1:0] rs1_i,
    input  logic [id_pkg::XLEN-1:0] rs2_i,
    input  logic [id_pkg::XLEN-1:0] imm_i,
    input  logic [id_pkg::XLEN-1:0] pc_i,
    input  logic                    stall_i,
    output logic                    brj_o,
    output logic [id_pkg::XLEN-1:0] brj_pc_o
);

    logic                    taken;
    logic [id_pkg::XLEN-1:0] jalr_sum;

    always_comb
    begin
        case (br_op_i)
            id_pkg::BR_EQ:   taken = (rs1_i == rs2_i);
            id_pkg::BR_NE:   taken = (rs1_i != rs2_i);
            id_pkg::BR_LT:   taken = ($signed(rs1_i) <  $signed(rs2_i));
            id_pkg::BR_GE:   taken = ($signed(rs1_i) >= $signed(rs2_i));
            id_pkg::BR_LTU:  taken = (rs1_i <  rs2_i);
            id_pkg::BR_GEU:  taken = (rs1_i >= rs2_i);
            id_pkg::BR_JAL,
            id_pkg::BR_JALR: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    assign jalr_sum = rs1_i + imm_i;

    // JALR clears bit 0 of the sum, everything else is pc-relative
    assign brj_pc_o = (br_op_i == id_pkg::BR_JALR) ? {jalr_sum[id_pkg::XLEN-1:1], 1'b0}
                                                   : pc_i + imm_i;

    assign brj_o = taken && !stall_i; // Operands not valid during a stall

endmodule

/* logic/id_operand_fwd.sv */
module id_operand_fwd
(
    input  id_pkg::dec_ctrl_t       ctrl_i,
    input  logic [id_pkg::XLEN-1:0] rf_rs1_i,
    input  logic [id_pkg::XLEN-1:0] rf_rs2_i,
    input  id_pkg::dec_ctrl_t       ex_ctrl_i,  // Instruction now in EXE
    input  logic [id_pkg::XLEN-1:0] alu_i,
    input  id_pkg::mem_fwd_t        mem_fwd_i,
    input  id_pkg::wb_write_t       wb_write_i,
    output logic [id_pkg::XLEN-1:0] rs1_o,
    output logic [id_pkg::XLEN-1:0] rs2_o,
    output logic                    stall_o
);

    // Youngest producer wins in the order EXE, MEM, WB and the file
    function automatic logic [id_pkg::XLEN-1:0] pick_operand
    (
        input logic [id_pkg::REG_ADDR_W-1:0] addr,
        input logic [id_pkg::XLEN-1:0]       rf_val
    );
        logic [id_pkg::XLEN-1:0] val;
        val = rf_val;
        if (addr != '0)
        begin
            if (ex_ctrl_i.reg_wr && ex_ctrl_i.rd == addr)
                val = alu_i;
            else if (mem_fwd_i.valid && mem_fwd_i.addr == addr)
                val = mem_fwd_i.data;
            else if (wb_write_i.valid && wb_write_i.addr == addr)
                val = wb_write_i.data;
        end
        return val;
    endfunction

    always_comb
    begin
        rs1_o = pick_operand(ctrl_i.rs1, rf_rs1_i);
        rs2_o = pick_operand(ctrl_i.rs2, rf_rs2_i);
    end

    always_comb
    begin
        logic ex_load_hit;
        logic mem_load_hit;
        ex_load_hit  = ex_ctrl_i.mem_rd && ex_ctrl_i.rd != '0
                       && (ex_ctrl_i.rd == ctrl_i.rs1 || ex_ctrl_i.rd == ctrl_i.rs2);
        mem_load_hit = mem_fwd_i.is_load && mem_fwd_i.addr != '0
                       && (mem_fwd_i.addr == ctrl_i.rs1 || mem_fwd_i.addr == ctrl_i.rs2);
        stall_o      = ex_load_hit || mem_load_hit; // Wait for the load data
    end

endmodule

/* logic/id_regfile.sv */
module id_regfile
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  id_pkg::wb_write_t             wb_write_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [id_pkg::XLEN-1:0]       rs1_data_o,
    output logic [id_pkg::XLEN-1:0]       rs2_data_o
);

    logic [id_pkg::XLEN-1:0] regs [id_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < id_pkg::NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_write_i.valid && wb_write_i.addr != '0) // x0 stays zero
        begin
            regs[wb_write_i.addr] <= wb_write_i.data;
        end
    end

    // Same-cycle WB data reaches the operands through the forwarding unit
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    wb_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_write_i.valid |-> !$isunknown(wb_write_i.addr)
    ) else $error("WB write with unknown register address");

endmodule

/* logic/id_decoder.sv */
module id_decoder
(
    input  id_pkg::instr_u          instr_i,
    output id_pkg::dec_ctrl_t       ctrl_o,
    output logic [id_pkg::XLEN-1:0] imm_o
);

    logic [id_pkg::XLEN-1:0] imm_i_fmt;
    logic [id_pkg::XLEN-1:0] imm_s_fmt;
    logic [id_pkg::XLEN-1:0] imm_b_fmt;
    logic [id_pkg::XLEN-1:0] imm_u_fmt;
    logic [id_pkg::XLEN-1:0] imm_j_fmt;
    id_pkg::alu_op_e         arith_op; // OP and OP-IMM operation
    id_pkg::br_op_e          cond_op;  // Branch condition from funct3
    logic                    alt_op;   // funct7[5] selects SUB or SRA

    assign imm_i_fmt = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
    assign imm_s_fmt = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
    assign imm_b_fmt = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                        instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
    assign imm_u_fmt = {instr_i.u.imm31_12, 12'b0};
    assign imm_j_fmt = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                        instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};

    assign alt_op = instr_i.r.funct7[5];

    always_comb
    begin
        case (instr_i.r.funct3)
            3'b000:
            begin
                // OP-IMM has no SUBI, bit 30 is part of the immediate there
                if (instr_i.r.opcode == id_pkg::OPC_OP && alt_op)
                    arith_op = id_pkg::ALU_SUB;
                else
                    arith_op = id_pkg::ALU_ADD;
            end
            3'b001:  arith_op = id_pkg::ALU_SLL;
            3'b010:  arith_op = id_pkg::ALU_SLT;
            3'b011:  arith_op = id_pkg::ALU_SLTU;
            3'b100:  arith_op = id_pkg::ALU_XOR;
            3'b101:  arith_op = alt_op ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
            3'b110:  arith_op = id_pkg::ALU_OR;
            default: arith_op = id_pkg::ALU_AND;
        endcase
    end

    always_comb
    begin
        case (instr_i.b.funct3)
            3'b000:  cond_op = id_pkg::BR_EQ;
            3'b001:  cond_op = id_pkg::BR_NE;
            3'b100:  cond_op = id_pkg::BR_LT;
            3'b101:  cond_op = id_pkg::BR_GE;
            3'b110:  cond_op = id_pkg::BR_LTU;
            3'b111:  cond_op = id_pkg::BR_GEU;
            default: cond_op = id_pkg::BR_NONE; // Reserved encodings never branch
        endcase
    end

    always_comb
    begin
        ctrl_o = '0; // Bubble unless the opcode is known
        imm_o  = '0;
        case (instr_i.r.opcode)
            id_pkg::OPC_OP:
            begin
                ctrl_o.alu_op = arith_op;
                ctrl_o.reg_wr = 1'b1;
                ctrl_o.rd     = instr_i.r.rd;
                ctrl_o.rs1    = instr_i.r.rs1;
                ctrl_o.rs2    = instr_i.r.rs2;
            end
            id_pkg::OPC_OP_IMM:
            begin
                ctrl_o.alu_op  = arith_op;
                ctrl_o.src_imm = 1'b1;
                ctrl_o.reg_wr  = 1'b1;
                ctrl_o.rd      = instr_i.i.rd;
                ctrl_o.rs1     = instr_i.i.rs1;
                imm_o          = imm_i_fmt;
            end
            id_pkg::OPC_LOAD:
            begin
                ctrl_o.src_imm  = 1'b1;      // Address is rs1 + imm
                ctrl_o.mem_rd   = 1'b1;
                ctrl_o.mem_size = instr_i.i.funct3;
                ctrl_o.reg_wr   = 1'b1;
                ctrl_o.rd       = instr_i.i.rd;
                ctrl_o.rs1      = instr_i.i.rs1;
                imm_o           = imm_i_fmt;
            end
            id_pkg::OPC_STORE:
            begin
                ctrl_o.src_imm  = 1'b1;
                ctrl_o.mem_wr   = 1'b1;
                ctrl_o.mem_size = instr_i.s.funct3;
                ctrl_o.rs1      = instr_i.s.rs1;
                ctrl_o.rs2      = instr_i.s.rs2; // Store data
                imm_o           = imm_s_fmt;
            end
            id_pkg::OPC_BRANCH:
            begin
                ctrl_o.br_op = cond_op;
                ctrl_o.rs1   = instr_i.b.rs1;
                ctrl_o.rs2   = instr_i.b.rs2;
                imm_o        = imm_b_fmt;
            end
            id_pkg::OPC_JAL:
            begin
                ctrl_o.br_op  = id_pkg::BR_JAL;
                ctrl_o.reg_wr = 1'b1;          // Link register gets pc + 4
                ctrl_o.rd     = instr_i.j.rd;
                imm_o         = imm_j_fmt;
            end
            id_pkg::OPC_JALR:
            begin
                ctrl_o.br_op   = id_pkg::BR_JALR;
                ctrl_o.src_imm = 1'b1;
                ctrl_o.reg_wr  = 1'b1;
                ctrl_o.rd      = instr_i.i.rd;
                ctrl_o.rs1     = instr_i.i.rs1;
                imm_o          = imm_i_fmt;
            end
            id_pkg::OPC_LUI:
            begin
                ctrl_o.alu_op  = id_pkg::ALU_PASS_B;
                ctrl_o.src_imm = 1'b1;
                ctrl_o.reg_wr  = 1'b1;
                ctrl_o.rd      = instr_i.u.rd;
                imm_o          = imm_u_fmt;
            end
            default: ;
        endcase
    end

endmodule

/* logic/id_pkg.sv */
package id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int ALU_OP_W   = 4;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD    = 4'd0, // Zero so a cleared bundle is an ADD
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10 // LUI result
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_EQ   = 4'd1,
        BR_NE   = 4'd2,
        BR_LT   = 4'd3,
        BR_GE   = 4'd4,
        BR_LTU  = 4'd5,
        BR_GEU  = 4'd6,
        BR_JAL  = 4'd7,
        BR_JALR = 4'd8
    } br_op_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi; // imm[11:5]
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo; // imm[4:0]
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm31_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm20;
        logic [9:0]            imm10_1;
        logic                  imm11;
        logic [7:0]            imm19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        alu_op_e               alu_op;
        br_op_e                br_op;
        logic                  src_imm;  // Immediate as second ALU input
        logic                  mem_rd;
        logic                  mem_wr;
        logic [2:0]            mem_size; // funct3 of the access
        logic                  reg_wr;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;      // Zero when the format has no rs1
        logic [REG_ADDR_W-1:0] rs2;      // Zero when the format has no rs2
    } dec_ctrl_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
        logic                  is_load; // Load data still in flight
    } mem_fwd_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } wb_write_t;

    typedef struct packed {
        dec_ctrl_t       ctrl;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] pc4;
        logic [XLEN-1:0] brj_pc;
    } ex_bundle_t;

endpackage
